/* verilog/deskew_pkg.sv */
// Array geometry, beat and word structs, and index types for the deskew drain
package deskew_pkg;

    // ============================================================
    // Array geometry
    // ============================================================
    localparam int ACT_WIDTH      = 8;
    localparam int NUM_ROW        = 4;
    localparam int NUM_BANK       = 2;
    localparam int BEATS_PER_TILE = 2 * NUM_ROW - 1;

    // Derived index widths
    localparam int ROW_AW  = (NUM_ROW > 1) ? $clog2(NUM_ROW) : 1;
    localparam int BANK_W  = (NUM_BANK > 1) ? $clog2(NUM_BANK) : 1;
    localparam int BEAT_W  = (BEATS_PER_TILE > 1) ? $clog2(BEATS_PER_TILE) : 1;

    // ============================================================
    // Types
    // ============================================================
    typedef logic [ROW_AW-1:0] row_addr_t;
    typedef logic [BANK_W-1:0] bank_id_t;
    typedef logic [BEAT_W-1:0] beat_cnt_t;

    // Element j belongs to row j
    typedef logic [NUM_ROW-1:0][ACT_WIDTH-1:0] row_vec_t;

    // One skewed input beat of a bank
    typedef struct packed {
        row_vec_t           data;
        logic [NUM_ROW-1:0] valid;
    } in_beat_t;

    // One aligned output word, tagged with its source
    typedef struct packed {
        row_vec_t  data;
        bank_id_t  bank;
        row_addr_t idx;
    } out_word_t;

endpackage

/* verilog/row_ram.sv */
// One-row storage: 1-write 1-read RAM with registered read port
`timescale 1ns/10ps

module row_ram
    import deskew_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 wr_en_i,
    input  row_addr_t            wr_addr_i,
    input  logic [ACT_WIDTH-1:0] wr_data_i,
    input  logic                 rd_en_i,
    input  row_addr_t            rd_addr_i,
    output logic [ACT_WIDTH-1:0] rd_data_o
);

    logic [ACT_WIDTH-1:0] mem [NUM_ROW];
    logic [ACT_WIDTH-1:0] rd_data_q;

    // Storage array
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // Read register keeps its value between reads
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_data_q <= '0;
        end else if (rd_en_i) begin
            rd_data_q <= mem[rd_addr_i];
        end
    end

    assign rd_data_o = rd_data_q;

endmodule

/* verilog/sync_fifo.sv */
// Synchronous first-word fall-through FIFO with generic payload and occupancy count
`timescale 1ns/10ps

module sync_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 4
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       push_i,
    input  payload_t                   push_data_i,
    input  logic                       pop_i,
    output payload_t                   pop_data_o,
    output logic                       empty_o,
    output logic                       full_o,
    output logic [$clog2(DEPTH+1)-1:0] count_o
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    payload_t      mem [DEPTH];
    logic [AW-1:0] wr_ptr_q;
    logic [AW-1:0] rd_ptr_q;
    logic [CW-1:0] count_q;

    // Wrap at DEPTH so non power-of-two depths work
    function automatic logic [AW-1:0] ptr_next(input logic [AW-1:0] ptr);
        return (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (push_i) begin
            mem[wr_ptr_q] <= push_data_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= ptr_next(wr_ptr_q);
            end
            if (pop_i) begin
                rd_ptr_q <= ptr_next(rd_ptr_q);
            end
            case ({push_i, pop_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // Head of queue is visible without a pop
    assign pop_data_o = mem[rd_ptr_q];
    assign empty_o    = (count_q == '0);
    assign full_o     = (count_q == CW'(DEPTH));
    assign count_o    = count_q;

endmodule

/* verilog/bank_deskew.sv */
// Per-bank skew correction: beat counting, row RAM array, drain control, output FIFO
`timescale 1ns/10ps

module bank_deskew
    import deskew_pkg::*;
#(
    parameter int FIFO_DEPTH = 4
) (
    input  logic      clk,
    input  logic      rst_n,
    input  in_beat_t  beat_i,
    input  logic      beat_valid_i,
    output logic      beat_ready_o,
    output row_vec_t  word_o,
    output row_addr_t word_idx_o,
    output logic      word_valid_o,
    input  logic      word_ready_i
);

    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
    localparam int RD_W  = $clog2(NUM_ROW + 1);

    typedef enum logic {
        ST_COLLECT,
        ST_DRAIN
    } state_t;

    state_t     state_q;
    beat_cnt_t  beat_cnt_q;
    logic [RD_W-1:0] rd_cnt_q;
    logic       rd_pend_q;
    row_addr_t  out_cnt_q;

    logic       beat_acc;
    logic       last_beat;
    logic       rd_en;
    logic       pop;
    logic       tile_done;
    row_vec_t   rd_vec;
    logic [CNT_W-1:0] fifo_count;
    logic       fifo_empty;

    // ============================================================
    // Input side
    // ============================================================
    assign beat_ready_o = (state_q == ST_COLLECT);
    assign beat_acc     = beat_valid_i && beat_ready_o;
    assign last_beat    = beat_acc && (beat_cnt_q == BEAT_W'(BEATS_PER_TILE - 1));

    // ============================================================
    // Processing part: one RAM per row
    // ============================================================
    for (genvar j = 0; j < NUM_ROW; j++) begin : g_row
        beat_cnt_t wr_off;

        // Row j lags row 0 by j beats
        assign wr_off = beat_cnt_q - BEAT_W'(j);

        row_ram row_ram_i (
            .clk       (clk),
            .rst_n     (rst_n),
            .wr_en_i   (beat_acc && beat_i.valid[j]),
            .wr_addr_i (wr_off[ROW_AW-1:0]),
            .wr_data_i (beat_i.data[j]),
            .rd_en_i   (rd_en),
            .rd_addr_i (rd_cnt_q[ROW_AW-1:0]),
            .rd_data_o (rd_vec[j])
        );
    end

    // Leave room for the read already in flight
    assign rd_en = (state_q == ST_DRAIN)
                && (rd_cnt_q < RD_W'(NUM_ROW))
                && ((int'(fifo_count) + int'(rd_pend_q)) < FIFO_DEPTH);

    // ============================================================
    // Output side
    // ============================================================
    sync_fifo #(
        .payload_t (row_vec_t),
        .DEPTH     (FIFO_DEPTH)
    ) out_fifo_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .push_i      (rd_pend_q),
        .push_data_i (rd_vec),
        .pop_i       (pop),
        .pop_data_o  (word_o),
        .empty_o     (fifo_empty),
        .full_o      (),
        .count_o     (fifo_count)
    );

    assign word_valid_o = !fifo_empty;
    assign word_idx_o   = out_cnt_q;
    assign pop          = word_valid_o && word_ready_i;
    assign tile_done    = pop && (out_cnt_q == ROW_AW'(NUM_ROW - 1));

    // Tile sequencing and counters
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= ST_COLLECT;
            beat_cnt_q <= '0;
            rd_cnt_q   <= '0;
            rd_pend_q  <= 1'b0;
            out_cnt_q  <= '0;
        end else begin
            rd_pend_q <= rd_en;
            if (tile_done) begin
                state_q    <= ST_COLLECT;
                beat_cnt_q <= '0;
                rd_cnt_q   <= '0;
                out_cnt_q  <= '0;
            end else begin
                if (last_beat) begin
                    state_q <= ST_DRAIN;
                end else if (beat_acc) begin
                    beat_cnt_q <= beat_cnt_q + 1'b1;
                end
                if (rd_en) begin
                    rd_cnt_q <= rd_cnt_q + 1'b1;
                end
                if (pop) begin
                    out_cnt_q <= out_cnt_q + 1'b1;
                end
            end
        end
    end

endmodule

/* verilog/bank_arbiter.sv */
// Round-robin merge of bank output words into one tagged output stream
`timescale 1ns/10ps

module bank_arbiter
    import deskew_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst_n,
    input  row_vec_t  [NUM_BANK-1:0]     word_i,
    input  row_addr_t [NUM_BANK-1:0]     word_idx_i,
    input  logic      [NUM_BANK-1:0]     word_valid_i,
    output logic      [NUM_BANK-1:0]     word_ready_o,
    output out_word_t                    out_o,
    output logic                         out_valid_o,
    input  logic                         out_ready_i
);

    bank_id_t last_q;
    logic     lock_q;
    bank_id_t lock_id_q;

    bank_id_t rr_id;
    logic     rr_found;
    bank_id_t grant_id;
    logic     xfer;

    // Search starts one past the bank served last
    always_comb begin
        int cand;
        rr_id    = last_q;
        rr_found = 1'b0;
        for (int off = 1; off <= NUM_BANK; off++) begin
            cand = (int'(last_q) + off) % NUM_BANK;
            if (!rr_found && word_valid_i[cand]) begin
                rr_found = 1'b1;
                rr_id    = bank_id_t'(cand);
            end
        end
    end

    // A stalled grant is held so out_o stays stable
    assign grant_id    = lock_q ? lock_id_q : rr_id;
    assign out_valid_o = |word_valid_i;
    assign xfer        = out_valid_o && out_ready_i;

    assign out_o.data = word_i[grant_id];
    assign out_o.idx  = word_idx_i[grant_id];
    assign out_o.bank = grant_id;

    always_comb begin
        word_ready_o = '0;
        if (xfer) begin
            word_ready_o[grant_id] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_q    <= bank_id_t'(NUM_BANK - 1);
            lock_q    <= 1'b0;
            lock_id_q <= '0;
        end else begin
            if (xfer) begin
                last_q <= grant_id;
                lock_q <= 1'b0;
            end else if (out_valid_o) begin
                lock_q    <= 1'b1;
                lock_id_q <= grant_id;
            end
        end
    end

endmodule

/* verilog/deskew_top.sv */
// Top level: per-bank deskew units feeding the round-robin output arbiter
`timescale 1ns/10ps

module deskew_top
    import deskew_pkg::*;
#(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  in_beat_t [NUM_BANK-1:0]  beat_i,
    input  logic     [NUM_BANK-1:0]  beat_valid_i,
    output logic     [NUM_BANK-1:0]  beat_ready_o,
    output out_word_t                out_o,
    output logic                     out_valid_o,
    input  logic                     out_ready_i
);

    row_vec_t  [NUM_BANK-1:0] bank_word;
    row_addr_t [NUM_BANK-1:0] bank_word_idx;
    logic      [NUM_BANK-1:0] bank_word_valid;
    logic      [NUM_BANK-1:0] bank_word_ready;

    // ============================================================
    // One deskew unit per bank
    // ============================================================
    for (genvar b = 0; b < NUM_BANK; b++) begin : g_bank
        bank_deskew #(
            .FIFO_DEPTH (FIFO_DEPTH)
        ) bank_deskew_i (
            .clk          (clk),
            .rst_n        (rst_n),
            .beat_i       (beat_i[b]),
            .beat_valid_i (beat_valid_i[b]),
            .beat_ready_o (beat_ready_o[b]),
            .word_o       (bank_word[b]),
            .word_idx_o   (bank_word_idx[b]),
            .word_valid_o (bank_word_valid[b]),
            .word_ready_i (bank_word_ready[b])
        );
    end

    // Merge into the single output stream
    bank_arbiter bank_arbiter_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .word_i       (bank_word),
        .word_idx_i   (bank_word_idx),
        .word_valid_i (bank_word_valid),
        .word_ready_o (bank_word_ready),
        .out_o        (out_o),
        .out_valid_o  (out_valid_o),
        .out_ready_i  (out_ready_i)
    );

endmodule

/* sim/deskew_asserts.sv */
// Concurrent handshake and drain assertions for the deskew top level, with its bind
`timescale 1ns/10ps

module deskew_asserts
    import deskew_pkg::*;
(
    input logic                     clk,
    input logic                     rst_n,
    input logic      [NUM_BANK-1:0] beat_ready_o,
    input out_word_t                out_o,
    input logic                     out_valid_o,
    input logic                     out_ready_i,
    input logic      [NUM_BANK-1:0] bank_word_valid,
    input logic      [NUM_BANK-1:0] bank_word_ready,
    input row_addr_t [NUM_BANK-1:0] bank_word_idx
);

    // Output holds while stalled
    assert property (@(posedge clk) disable iff (!rst_n)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_o))
        else $error("output changed or dropped while stalled");

    assert property (@(posedge clk) !rst_n |-> !out_valid_o)
        else $error("out_valid high during reset");

    // Input stays blocked until the last word of the tile leaves
    for (genvar b = 0; b < NUM_BANK; b++) begin : g_bank
        assert property (@(posedge clk) disable iff (!rst_n)
            !beat_ready_o[b] && !(bank_word_valid[b] && bank_word_ready[b]
                && bank_word_idx[b] == row_addr_t'(NUM_ROW - 1)) |=> !beat_ready_o[b])
            else $error("bank %0d accepted input before its drain ended", b);
    end

endmodule

bind deskew_top deskew_asserts deskew_asserts_i (.*);

/* sim/deskew_tb.sv */
// Directed deskew testbench with reference model, output monitor, compare task and watchdog
`timescale 1ns/10ps

module deskew_tb;
    import deskew_pkg::*;

    localparam int NUM_TILES = 12;

    logic                    clk;
    logic                    rst_n;
    in_beat_t [NUM_BANK-1:0] beat;
    logic     [NUM_BANK-1:0] beat_valid;
    logic     [NUM_BANK-1:0] beat_ready;
    out_word_t               out_word;
    logic                    out_valid;
    logic                    out_ready;

    // Expected words per bank, in output order
    out_word_t exp_q [NUM_BANK][$];
    logic      rand_ready;
    logic      check_alt;
    bank_id_t  last_bank;

    deskew_top #(
        .FIFO_DEPTH (4)
    ) deskew_top_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .beat_i       (beat),
        .beat_valid_i (beat_valid),
        .beat_ready_o (beat_ready),
        .out_o        (out_word),
        .out_valid_o  (out_valid),
        .out_ready_i  (out_ready)
    );

    always #4 clk = ~clk;

    task automatic compare(input string what, input logic [63:0] got, input logic [63:0] want);
        if (got !== want) begin
            $display("mismatch at %0t ns: %s got %0h expected %0h", $time, what, got, want);
            $display("TESTS FAILED");
            $fatal(1);
        end
    endtask

    function automatic int pending();
        int n;
        n = 0;
        for (int b = 0; b < NUM_BANK; b++) begin
            n += exp_q[b].size();
        end
        return n;
    endfunction

    // Output ready is random or steady and changes on the falling edge
    always @(negedge clk) begin
        out_ready = rand_ready ? 1'($urandom % 2) : 1'b1;
    end

    // Output monitor samples just before the rising edge
    always begin : monitor
        out_word_t want;
        @(negedge clk);
        #3;
        if (rst_n && out_valid && out_ready) begin
            compare("word expected from bank", 64'(exp_q[out_word.bank].size() > 0), 64'(1));
            if (check_alt && (&deskew_top_i.bank_word_valid)) begin
                compare("round-robin grant", 64'(out_word.bank),
                        64'(bank_id_t'((int'(last_bank) + 1) % NUM_BANK)));
            end
            last_bank = out_word.bank;
            want = exp_q[out_word.bank].pop_front();
            compare("output word", 64'(out_word), 64'(want));
        end
    end

    // Reference model builds a random tile, its expected words and the skewed beats
    task automatic send_tile(input int b, input bit gaps);
        logic [ACT_WIDTH-1:0] elem [NUM_ROW][NUM_ROW];
        out_word_t w;
        int k;
        for (int j = 0; j < NUM_ROW; j++) begin
            for (int e = 0; e < NUM_ROW; e++) begin
                elem[j][e] = ACT_WIDTH'($urandom);
            end
        end
        for (int e = 0; e < NUM_ROW; e++) begin
            w.bank = bank_id_t'(b);
            w.idx  = row_addr_t'(e);
            for (int j = 0; j < NUM_ROW; j++) begin
                w.data[j] = elem[j][e];
            end
            exp_q[b].push_back(w);
        end
        for (int t = 0; t < BEATS_PER_TILE; t++) begin
            if (gaps) begin
                beat_valid[b] = 1'b0;
                repeat ($urandom % 3) @(negedge clk);
            end
            // Row j carries element t-j and idle lanes get junk
            for (int j = 0; j < NUM_ROW; j++) begin
                k = t - j;
                beat[b].valid[j] = (k >= 0) && (k < NUM_ROW);
                beat[b].data[j]  = beat[b].valid[j] ? elem[j][k] : ACT_WIDTH'($urandom);
            end
            beat_valid[b] = 1'b1;
            while (!beat_ready[b]) begin
                @(negedge clk);
            end
            @(negedge clk);
        end
        beat_valid[b] = 1'b0;
    endtask

    task automatic wait_drain();
        while (pending() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic one_tile_after_reset();
        compare("beat_ready after reset", 64'(beat_ready), 64'({NUM_BANK{1'b1}}));
        compare("out_valid after reset", 64'(out_valid), 64'(0));
        send_tile(0, 1'b0);
        wait_drain();
    endtask

    task automatic gapped_input_tile();
        send_tile(1, 1'b1);
        wait_drain();
    endtask

    task automatic dual_bank_alternation();
        check_alt = 1'b1;
        fork
            send_tile(0, 1'b0);
            send_tile(1, 1'b0);
        join
        wait_drain();
        check_alt = 1'b0;
    endtask

    task automatic random_backpressure();
        rand_ready = 1'b1;
        fork
            repeat (3) send_tile(0, 1'b0);
            repeat (3) send_tile(1, 1'b1);
        join
        wait_drain();
        rand_ready = 1'b0;
    endtask

    task automatic drain_blocks_input();
        send_tile(0, 1'b0);
        while (pending() != 0) begin
            compare("beat_ready during drain", 64'(beat_ready[0]), 64'(0));
            @(negedge clk);
        end
        compare("beat_ready after drain", 64'(beat_ready[0]), 64'(1));
        send_tile(0, 1'b0);
        wait_drain();
    endtask

    // Watchdog
    initial begin
        repeat (NUM_TILES * 200) @(posedge clk);
        $display("error: the run timed out without finishing");
        $display("TESTS FAILED");
        $fatal(1);
    end

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        beat       = '0;
        beat_valid = '0;
        out_ready  = 1'b1;
        rand_ready = 1'b0;
        check_alt  = 1'b0;
        last_bank  = bank_id_t'(NUM_BANK - 1);
        void'($urandom(16));
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        one_tile_after_reset();
        gapped_input_tile();
        dual_bank_alternation();
        random_backpressure();
        drain_blocks_input();
        if (pending() != 0 || out_valid) begin
            $display("error: words were left over or an extra word appeared at the end of the run");
            $display("TESTS FAILED");
            $fatal(1);
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule

/* build.f */
verilog/deskew_pkg.sv
verilog/row_ram.sv
verilog/sync_fifo.sv
verilog/bank_deskew.sv
verilog/bank_arbiter.sv
verilog/deskew_top.sv
sim/deskew_asserts.sv
sim/deskew_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the deskew testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module deskew_tb -f build.f -o deskew_sim

./obj_dir/deskew_sim
